// File: filelist.f
logic/pce_pkg.sv
logic/pce_fifo.sv
logic/pce_req_encoder.sv
logic/pce_ret_decoder.sv
logic/pce_ctrl.sv
logic/pce_top.sv
test/pce_tb.sv

// File: Bender.yml
package:
  name: pce

sources:
  - logic/pce_pkg.sv
  - logic/pce_fifo.sv
  - logic/pce_req_encoder.sv
  - logic/pce_ret_decoder.sv
  - logic/pce_ctrl.sv
  - logic/pce_top.sv
  - target: test
    files:
      - test/pce_tb.sv

// File: test/pce_tb.sv
/* PCE bridge testbench */

`timescale 1ns/1ps
`default_nettype none

module pce_tb
  import pce_pkg::*;
();

  localparam int          N_REQ      = 400;
  localparam int          MAX_CYCLES = 100000;
  localparam logic [31:0] SEED       = 32'h5ecc_056c;

  logic             clk_i = 1'b0;
  logic             reset_i;
  cache_req_t       cache_req_i;
  logic             cache_req_v_i;
  logic             cache_req_yumi_o;
  logic [WAY_W-1:0] way_i;
  logic             way_v_i;
  logic             cache_req_complete_o;
  l15_req_t         pce_l15_req_o;
  logic             pce_l15_req_v_o;
  logic             pce_l15_req_ready_i;
  l15_ret_t         l15_pce_ret_i;
  logic             l15_pce_ret_v_i;
  logic             l15_pce_ret_ready_o;
  tag_pkt_t         tag_pkt_o;
  logic             tag_pkt_v_o;
  logic             tag_pkt_yumi_i;
  data_pkt_t        data_pkt_o;
  logic             data_pkt_v_o;
  logic             data_pkt_yumi_i;

  // Model state
  cache_req_t         pend_q[$];
  tag_pkt_t           inv_q[$];
  tag_pkt_t           inv_next;
  logic [WAY_W-1:0]   cur_way;
  logic [DWORD_W-1:0] ret_d0;
  logic [DWORD_W-1:0] ret_d1;
  logic               issued;
  logic               resp_due;
  logic               resp_sent;
  logic               tag_seen;
  logic               data_seen;
  logic               sweep_done;
  logic               req_taken;
  logic               ret_taken;
  logic               ret_is_resp;
  int                 resp_delay;
  int                 sweep_idx;
  int                 sent_reqs;
  int                 completed;
  int                 invals_seen;
  int                 ret_count;
  int                 checks;
  int                 errors;

  always #4 clk_i = ~clk_i;

  pce_top u_pce_top (
    .clk_i                (clk_i),
    .reset_i              (reset_i),
    .cache_req_i          (cache_req_i),
    .cache_req_v_i        (cache_req_v_i),
    .cache_req_yumi_o     (cache_req_yumi_o),
    .cache_req_way_i      (way_i),
    .cache_req_way_v_i    (way_v_i),
    .cache_req_complete_o (cache_req_complete_o),
    .pce_l15_req_o        (pce_l15_req_o),
    .pce_l15_req_v_o      (pce_l15_req_v_o),
    .pce_l15_req_ready_i  (pce_l15_req_ready_i),
    .l15_pce_ret_i        (l15_pce_ret_i),
    .l15_pce_ret_v_i      (l15_pce_ret_v_i),
    .l15_pce_ret_ready_o  (l15_pce_ret_ready_o),
    .tag_pkt_o            (tag_pkt_o),
    .tag_pkt_v_o          (tag_pkt_v_o),
    .tag_pkt_yumi_i       (tag_pkt_yumi_i),
    .data_pkt_o           (data_pkt_o),
    .data_pkt_v_o         (data_pkt_v_o),
    .data_pkt_yumi_i      (data_pkt_yumi_i)
  );

  function automatic logic is_store_msg(input req_msg_e m);
    return (m == e_uc_store) || (m == e_wt_store);
  endfunction

  function automatic logic is_miss_msg(input req_msg_e m);
    return (m == e_miss_load) || (m == e_miss_store);
  endfunction

  function automatic string msg_name(input req_msg_e m);
    case (m)
      e_miss_load:  return "miss_load";
      e_miss_store: return "miss_store";
      e_uc_load:    return "uc_load";
      e_uc_store:   return "uc_store";
      default:      return "wt_store";
    endcase
  endfunction

  function automatic logic [DWORD_W-1:0] swap_bytes(input logic [DWORD_W-1:0] d);
    logic [DWORD_W-1:0] r;
    r = {<<8{d}};
    return r;
  endfunction

  function automatic l15_req_t expect_l15_req(input cache_req_t r, input logic [WAY_W-1:0] way);
    l15_req_t e;
    int       n;
    e = '0;
    n = 1 << r.size;
    e.rqtype   = is_store_msg(r.msg_type) ? e_store_req : e_load_req;
    e.nc       = (r.msg_type == e_uc_store) || (r.msg_type == e_uc_load);
    e.address  = r.addr;
    e.l1rplway = {r.addr[11], way};
    case (r.size)
      e_size_1b: e.size = e_l15_size_1b;
      e_size_2b: e.size = e_l15_size_2b;
      e_size_4b: e.size = e_l15_size_4b;
      default:   e.size = e_l15_size_8b;
    endcase
    if (is_miss_msg(r.msg_type))
    begin
      e.size = e_l15_size_16b;
      e.address[OFFSET_W-1:0] = '0;
    end
    // Big endian order with the low request bytes repeated down the dword
    for (int i = 0; i < DWORD_W / 8; i++)
    begin
      e.data[DWORD_W-1-8*i -: 8] = r.data[8*(i % n) +: 8];
    end
    return e;
  endfunction

  function automatic logic [LINE_W-1:0] expect_uc_fill(input cache_req_t r,
                                                       input logic [DWORD_W-1:0] d0,
                                                       input logic [DWORD_W-1:0] d1);
    logic [DWORD_W-1:0] rev;
    logic [LINE_W-1:0]  f;
    int                 n;
    n   = 1 << r.size;
    rev = swap_bytes(r.addr[3] ? d1 : d0);
    for (int i = 0; i < LINE_W / 8; i++)
    begin
      f[8*i +: 8] = rev[8*(i % n) +: 8];
    end
    return f;
  endfunction

  task automatic compare_value(input string test, input string field,
                               input logic [LINE_W-1:0] exp, input logic [LINE_W-1:0] act);
    checks++;
    assert (exp === act)
    else
    begin
      errors++;
      $display("** Error [%s] %s: expected %h, actual %h", test, field, exp, act);
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1)
    else
    begin
      errors++;
      $display("Failure at %0t: %s", $time, what);
    end
  endtask

  // Runs at each rising edge before any register update is visible
  task automatic sample_outputs();
    cache_req_t head;
    tag_pkt_t   exp_tag;
    data_pkt_t  exp_dp;
    string      name;
    logic       yumi_exp;
    logic       req_v_exp;
    logic       ret_ready_exp;

    head = (pend_q.size() != 0) ? pend_q[0] : '0;
    name = msg_name(head.msg_type);

    yumi_exp = cache_req_v_i && (pend_q.size() < REQ_FIFO_ELS)
               && ((pend_q.size() == 0) || is_store_msg(head.msg_type));
    compare_value("request queue", "yumi", yumi_exp, cache_req_yumi_o);

    ret_ready_exp = (ret_count < RET_FIFO_ELS);
    compare_value("return queue", "ready", ret_ready_exp, l15_pce_ret_ready_o);

    req_v_exp = sweep_done && (pend_q.size() != 0) && !issued;
    compare_value("l15 request", "valid", req_v_exp, pce_l15_req_v_o);

    if (pce_l15_req_v_o)
    begin
      expect_true(sweep_done, "L1.5 request valid before the reset sweep finished");
      if (pce_l15_req_ready_i)
      begin
        expect_true(pend_q.size() != 0 && !issued, "L1.5 request with nothing to issue");
        compare_value(name, "l15 request", expect_l15_req(head, cur_way), pce_l15_req_o);
        issued     = 1'b1;
        resp_due   = 1'b1;
        resp_delay = $urandom_range(0, 6);
      end
    end

    if (l15_pce_ret_v_i && l15_pce_ret_ready_o)
    begin
      ret_taken = 1'b1;
      ret_count++;
      if (ret_is_resp)
      begin
        resp_sent = 1'b1;
      end
      else
      begin
        inv_q.push_back(inv_next);
      end
    end

    if (tag_pkt_v_o && tag_pkt_yumi_i)
    begin
      if (!sweep_done)
      begin
        exp_tag        = '0;
        exp_tag.opcode = e_tag_set_state;
        exp_tag.index  = INDEX_W'(sweep_idx);
        exp_tag.state  = e_coh_i;
        compare_value("reset sweep", "tag packet",
                      {exp_tag.opcode, exp_tag.index, exp_tag.state},
                      {tag_pkt_o.opcode, tag_pkt_o.index, tag_pkt_o.state});
        sweep_idx++;
        sweep_done = (sweep_idx == SETS);
      end
      else if (tag_pkt_o.opcode == e_tag_set_state)
      begin
        expect_true(inv_q.size() != 0, "set_state tag packet with no invalidation sent");
        exp_tag = (inv_q.size() != 0) ? inv_q.pop_front() : '0;
        compare_value("invalidation", "tag packet",
                      {exp_tag.opcode, exp_tag.index, exp_tag.way, exp_tag.state},
                      {tag_pkt_o.opcode, tag_pkt_o.index, tag_pkt_o.way, tag_pkt_o.state});
        invals_seen++;
        ret_count--;
      end
      else
      begin
        expect_true(is_miss_msg(head.msg_type) && resp_sent && !tag_seen,
                    "set_tag packet with no miss return consumed");
        exp_tag.opcode = e_tag_set_tag;
        exp_tag.index  = head.addr[OFFSET_W +: INDEX_W];
        exp_tag.way    = cur_way;
        exp_tag.tag    = head.addr[PADDR_W-1 -: TAG_W];
        exp_tag.state  = e_coh_m;
        compare_value(name, "tag packet", exp_tag, tag_pkt_o);
        tag_seen = 1'b1;
      end
    end

    if (data_pkt_v_o && data_pkt_yumi_i)
    begin
      expect_true(!is_store_msg(head.msg_type) && resp_sent && !data_seen,
                  "data packet with no load return consumed");
      exp_dp.index = head.addr[OFFSET_W +: INDEX_W];
      exp_dp.way   = cur_way;
      if (head.msg_type == e_uc_load)
      begin
        exp_dp.opcode = e_data_uncached;
        exp_dp.data   = expect_uc_fill(head, ret_d0, ret_d1);
      end
      else
      begin
        exp_dp.opcode = e_data_write;
        exp_dp.data   = {swap_bytes(ret_d1), swap_bytes(ret_d0)};
      end
      compare_value(name, "data header", {exp_dp.opcode, exp_dp.index, exp_dp.way},
                    {data_pkt_o.opcode, data_pkt_o.index, data_pkt_o.way});
      compare_value(name, "data line", exp_dp.data, data_pkt_o.data);
      data_seen = 1'b1;
    end

    if (cache_req_complete_o)
    begin
      expect_true(pend_q.size() != 0 && issued, "completion with no request issued");
      if (is_store_msg(head.msg_type))
      begin
        expect_true(resp_sent, "store completed before its st_ack");
      end
      else if (head.msg_type == e_uc_load)
      begin
        expect_true(data_seen, "uncached load completed without its data packet");
      end
      else
      begin
        expect_true(tag_seen && data_seen, "miss completed without tag and data packets");
      end
      if (pend_q.size() != 0)
      begin
        void'(pend_q.pop_front());
      end
      completed++;
      ret_count--;
      issued    = 1'b0;
      resp_sent = 1'b0;
      tag_seen  = 1'b0;
      data_seen = 1'b0;
    end

    if (cache_req_v_i && cache_req_yumi_o)
    begin
      pend_q.push_back(cache_req_i);
      req_taken = 1'b1;
    end
    if (way_v_i)
    begin
      cur_way = way_i;
    end
  endtask

  // Runs on the falling edge
  task automatic drive_inputs();
    cache_req_t r;
    l15_ret_t   ret;

    if (req_taken)
    begin
      cache_req_v_i = 1'b0;
      way_v_i       = 1'b0;
      req_taken     = 1'b0;
    end
    if (!cache_req_v_i && (sent_reqs < N_REQ) && ($urandom_range(0, 1) == 1))
    begin
      r.msg_type = req_msg_e'($urandom_range(0, 4));
      r.size     = req_size_e'($urandom_range(0, 3));
      r.addr     = $urandom;
      r.data     = {$urandom, $urandom};
      // A miss only enters an empty queue so its way stays put until it fills
      if (!is_miss_msg(r.msg_type) || (pend_q.size() == 0))
      begin
        cache_req_i   = r;
        cache_req_v_i = 1'b1;
        way_i         = WAY_W'($urandom_range(0, ASSOC - 1));
        way_v_i       = is_miss_msg(r.msg_type);
        sent_reqs++;
      end
    end

    if (ret_taken)
    begin
      l15_pce_ret_v_i = 1'b0;
      ret_taken       = 1'b0;
    end
    if (resp_due && !l15_pce_ret_v_i)
    begin
      if (resp_delay > 0)
      begin
        resp_delay--;
      end
      else
      begin
        ret              = '0;
        ret.rtntype      = is_store_msg(pend_q[0].msg_type) ? e_st_ack : e_load_ret;
        ret.noncacheable = (pend_q[0].msg_type == e_uc_load);
        ret.data_0       = {$urandom, $urandom};
        ret.data_1       = {$urandom, $urandom};
        ret_d0           = ret.data_0;
        ret_d1           = ret.data_1;
        l15_pce_ret_i    = ret;
        l15_pce_ret_v_i  = 1'b1;
        ret_is_resp      = 1'b1;
        resp_due         = 1'b0;
      end
    end
    else if (!l15_pce_ret_v_i && sweep_done && (completed < N_REQ)
             && ($urandom_range(0, 15) == 0))
    begin
      ret             = '0;
      ret.rtntype     = e_inv_ret;
      ret.inval       = 1'b1;
      ret.inval_way   = WAY_W'($urandom_range(0, ASSOC - 1));
      ret.inval_index = INDEX_W'($urandom_range(0, SETS - 1));
      ret.data_0      = {$urandom, $urandom};
      inv_next        = '0;
      inv_next.opcode = e_tag_set_state;
      inv_next.index  = ret.inval_index;
      inv_next.way    = ret.inval_way;
      inv_next.state  = e_coh_i;
      l15_pce_ret_i   = ret;
      l15_pce_ret_v_i = 1'b1;
      ret_is_resp     = 1'b0;
    end

    pce_l15_req_ready_i = ($urandom_range(0, 2) != 0);
    tag_pkt_yumi_i      = ($urandom_range(0, 3) != 0);
    data_pkt_yumi_i     = ($urandom_range(0, 3) != 0);
  endtask

  initial
  begin
    int   cycles;
    logic done;

    void'($urandom(SEED));
    reset_i             = 1'b1;
    cache_req_i         = '0;
    cache_req_v_i       = 1'b0;
    way_i               = '0;
    way_v_i             = 1'b1;
    pce_l15_req_ready_i = 1'b0;
    l15_pce_ret_i       = '0;
    l15_pce_ret_v_i     = 1'b0;
    tag_pkt_yumi_i      = 1'b0;
    data_pkt_yumi_i     = 1'b0;
    cur_way     = '0;
    inv_next    = '0;
    ret_d0      = '0;
    ret_d1      = '0;
    issued      = 1'b0;
    resp_due    = 1'b0;
    resp_sent   = 1'b0;
    tag_seen    = 1'b0;
    data_seen   = 1'b0;
    sweep_done  = 1'b0;
    req_taken   = 1'b0;
    ret_taken   = 1'b0;
    ret_is_resp = 1'b0;
    resp_delay  = 0;
    sweep_idx   = 0;
    sent_reqs   = 0;
    completed   = 0;
    invals_seen = 0;
    ret_count   = 0;
    checks      = 0;
    errors      = 0;

    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    way_v_i = 1'b0;
    expect_true(tag_pkt_v_o && !pce_l15_req_v_o && !data_pkt_v_o && !cache_req_complete_o,
                "outputs after reset are not in the sweep state");

    cycles = 0;
    done   = 1'b0;
    while (!done && (cycles < MAX_CYCLES))
    begin
      @(posedge clk_i);
      sample_outputs();
      @(negedge clk_i);
      drive_inputs();
      cycles++;
      done = (completed == N_REQ) && sweep_done && (inv_q.size() == 0) && !l15_pce_ret_v_i;
    end

    if (!done)
    begin
      errors++;
      $display("Timeout after %0d cycles with %0d of %0d requests completed",
               cycles, completed, N_REQ);
    end
    $display("checks %0d, errors %0d, completed %0d, invalidations %0d",
             checks, errors, completed, invals_seen);
    if (errors == 0)
    begin
      $display("SIMULATION PASSED");
    end
    else
    begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/pce_top.sv
/* PCE bridge top */

`timescale 1ns/1ps
`default_nettype none

module pce_top
  import pce_pkg::*;
(
  input  logic             clk_i,
  input  logic             reset_i,

  input  cache_req_t       cache_req_i,
  input  logic             cache_req_v_i,
  output logic             cache_req_yumi_o,
  input  logic [WAY_W-1:0] cache_req_way_i,
  input  logic             cache_req_way_v_i,
  output logic             cache_req_complete_o,

  output l15_req_t         pce_l15_req_o,
  output logic             pce_l15_req_v_o,
  input  logic             pce_l15_req_ready_i,

  input  l15_ret_t         l15_pce_ret_i,
  input  logic             l15_pce_ret_v_i,
  output logic             l15_pce_ret_ready_o,

  output tag_pkt_t         tag_pkt_o,
  output logic             tag_pkt_v_o,
  input  logic             tag_pkt_yumi_i,
  output data_pkt_t        data_pkt_o,
  output logic             data_pkt_v_o,
  input  logic             data_pkt_yumi_i
);

  cache_req_t        req_head;
  logic              req_head_v;
  logic              req_fifo_ready;
  logic              req_pop;
  l15_ret_t          ret_head;
  logic              ret_head_v;
  logic              ret_pop;
  logic [WAY_W-1:0]  way_lo;
  l15_req_t          l15_req_lo;
  logic              is_load_ret;
  logic              is_st_ack;
  logic              inval_v;
  logic [LINE_W-1:0] fill_line;
  logic [LINE_W-1:0] fill_uc;
  tag_pkt_t          inval_pkt;

  // Stores may queue behind a store and anything waits behind a load
  assign cache_req_yumi_o = cache_req_v_i & req_fifo_ready
    & (~req_head_v | (req_head.msg_type inside {e_uc_store, e_wt_store}));

  pce_fifo #(
    .payload_t (cache_req_t),
    .ELS       (REQ_FIFO_ELS)
  ) u_req_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .data_i  (cache_req_i),
    .v_i     (cache_req_yumi_o),
    .ready_o (req_fifo_ready),
    .data_o  (req_head),
    .v_o     (req_head_v),
    .yumi_i  (req_pop)
  );

  pce_fifo #(
    .payload_t (l15_ret_t),
    .ELS       (RET_FIFO_ELS)
  ) u_ret_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .data_i  (l15_pce_ret_i),
    .v_i     (l15_pce_ret_v_i & l15_pce_ret_ready_o),
    .ready_o (l15_pce_ret_ready_o),
    .data_o  (ret_head),
    .v_o     (ret_head_v),
    .yumi_i  (ret_pop)
  );

  pce_req_encoder u_req_encoder (
    .req_i (req_head),
    .way_i (way_lo),
    .req_o (l15_req_lo)
  );

  pce_ret_decoder u_ret_decoder (
    .ret_i         (ret_head),
    .ret_v_i       (ret_head_v),
    .req_i         (req_head),
    .is_load_ret_o (is_load_ret),
    .is_st_ack_o   (is_st_ack),
    .inval_v_o     (inval_v),
    .fill_line_o   (fill_line),
    .fill_uc_o     (fill_uc),
    .inval_pkt_o   (inval_pkt)
  );

  pce_ctrl u_ctrl (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .req_v_i             (req_head_v),
    .req_i               (req_head),
    .way_i               (cache_req_way_i),
    .way_v_i             (cache_req_way_v_i),
    .way_o               (way_lo),
    .l15_req_i           (l15_req_lo),
    .is_load_ret_i       (is_load_ret),
    .is_st_ack_i         (is_st_ack),
    .inval_v_i           (inval_v),
    .fill_line_i         (fill_line),
    .fill_uc_i           (fill_uc),
    .inval_pkt_i         (inval_pkt),
    .ret_v_i             (ret_head_v),
    .pce_l15_req_o       (pce_l15_req_o),
    .pce_l15_req_v_o     (pce_l15_req_v_o),
    .pce_l15_req_ready_i (pce_l15_req_ready_i),
    .ret_yumi_o          (ret_pop),
    .req_yumi_o          (req_pop),
    .complete_o          (cache_req_complete_o),
    .tag_pkt_o           (tag_pkt_o),
    .tag_pkt_v_o         (tag_pkt_v_o),
    .tag_pkt_yumi_i      (tag_pkt_yumi_i),
    .data_pkt_o          (data_pkt_o),
    .data_pkt_v_o        (data_pkt_v_o),
    .data_pkt_yumi_i     (data_pkt_yumi_i)
  );

endmodule

`default_nettype wire

// File: logic/pce_ctrl.sv
/* PCE control FSM */

`timescale 1ns/1ps
`default_nettype none

module pce_ctrl
  import pce_pkg::*;
(
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              req_v_i,
  input  cache_req_t        req_i,
  input  logic [WAY_W-1:0]  way_i,
  input  logic              way_v_i,
  output logic [WAY_W-1:0]  way_o,
  input  l15_req_t          l15_req_i,
  input  logic              is_load_ret_i,
  input  logic              is_st_ack_i,
  input  logic              inval_v_i,
  input  logic [LINE_W-1:0] fill_line_i,
  input  logic [LINE_W-1:0] fill_uc_i,
  input  tag_pkt_t          inval_pkt_i,
  input  logic              ret_v_i,
  output l15_req_t          pce_l15_req_o,
  output logic              pce_l15_req_v_o,
  input  logic              pce_l15_req_ready_i,
  output logic              ret_yumi_o,
  output logic              req_yumi_o,
  output logic              complete_o,
  output tag_pkt_t          tag_pkt_o,
  output logic              tag_pkt_v_o,
  input  logic              tag_pkt_yumi_i,
  output data_pkt_t         data_pkt_o,
  output logic              data_pkt_v_o,
  input  logic              data_pkt_yumi_i
);

  typedef enum logic [2:0] {
    e_clear,
    e_ready,
    e_store_wait,
    e_uc_wait,
    e_fill_wait
  } state_e;

  state_e             state_r;
  state_e             state_n;
  logic [INDEX_W-1:0] index_r;
  logic               index_up;
  logic [WAY_W-1:0]   way_r;
  logic               tag_sent_r;
  logic               data_sent_r;
  logic               tag_ack;
  logic               data_ack;
  logic [INDEX_W-1:0] req_index;
  logic [TAG_W-1:0]   req_tag;

  assign req_index = req_i.addr[OFFSET_W +: INDEX_W];
  assign req_tag   = req_i.addr[OFFSET_W + INDEX_W +: TAG_W];

  // Way passes straight through in its capture cycle
  assign way_o = way_v_i ? way_i : way_r;

  always_ff @(posedge clk_i)
  begin
    if (way_v_i)
    begin
      way_r <= way_i;
    end
  end

  assign req_yumi_o = complete_o;

  always_comb
  begin
    state_n         = state_r;
    index_up        = 1'b0;
    tag_ack         = 1'b0;
    data_ack        = 1'b0;
    pce_l15_req_o   = l15_req_i;
    pce_l15_req_v_o = 1'b0;
    ret_yumi_o      = 1'b0;
    complete_o      = 1'b0;
    tag_pkt_o       = '0;
    tag_pkt_v_o     = 1'b0;
    data_pkt_o      = '0;
    data_pkt_v_o    = 1'b0;

    unique case (state_r)
      e_clear:
      begin
        tag_pkt_o.opcode = e_tag_set_state;
        tag_pkt_o.index  = index_r;
        tag_pkt_o.state  = e_coh_i;
        tag_pkt_v_o      = 1'b1;
        index_up         = tag_pkt_yumi_i & ~inval_v_i;
        if (index_up && (index_r == INDEX_W'(SETS - 1)))
        begin
          state_n = e_ready;
        end
      end
      e_ready:
      begin
        pce_l15_req_v_o = req_v_i;
        if (req_v_i && pce_l15_req_ready_i)
        begin
          unique case (req_i.msg_type)
            e_uc_store, e_wt_store: state_n = e_store_wait;
            e_uc_load:              state_n = e_uc_wait;
            default:                state_n = e_fill_wait;
          endcase
        end
      end
      e_store_wait:
      begin
        ret_yumi_o = is_st_ack_i;
        complete_o = is_st_ack_i;
        if (complete_o)
        begin
          state_n = e_ready;
        end
      end
      e_uc_wait:
      begin
        data_pkt_o.opcode = e_data_uncached;
        data_pkt_o.index  = req_index;
        data_pkt_o.way    = way_o;
        data_pkt_o.data   = fill_uc_i;
        data_pkt_v_o      = is_load_ret_i;
        ret_yumi_o        = is_load_ret_i & data_pkt_yumi_i;
        complete_o        = ret_yumi_o;
        if (complete_o)
        begin
          state_n = e_ready;
        end
      end
      e_fill_wait:
      begin
        tag_pkt_o.opcode  = e_tag_set_tag;
        tag_pkt_o.index   = req_index;
        tag_pkt_o.way     = way_o;
        tag_pkt_o.tag     = req_tag;
        tag_pkt_o.state   = e_coh_m;
        tag_pkt_v_o       = is_load_ret_i & ~tag_sent_r;
        data_pkt_o.opcode = e_data_write;
        data_pkt_o.index  = req_index;
        data_pkt_o.way    = way_o;
        data_pkt_o.data   = fill_line_i;
        data_pkt_v_o      = is_load_ret_i & ~data_sent_r;
        tag_ack           = tag_pkt_v_o & tag_pkt_yumi_i;
        data_ack          = data_pkt_v_o & data_pkt_yumi_i;
        // Tag and data may be taken in different cycles
        ret_yumi_o = is_load_ret_i & (tag_sent_r | tag_ack) & (data_sent_r | data_ack);
        complete_o = ret_yumi_o;
        if (complete_o)
        begin
          state_n = e_ready;
        end
      end
      default:
      begin
        state_n = e_clear;
      end
    endcase

    // Invalidations win the tag port in every state
    if (inval_v_i)
    begin
      tag_pkt_o   = inval_pkt_i;
      tag_pkt_v_o = 1'b1;
      ret_yumi_o  = tag_pkt_yumi_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r     <= e_clear;
      index_r     <= '0;
      tag_sent_r  <= 1'b0;
      data_sent_r <= 1'b0;
    end
    else
    begin
      state_r <= state_n;
      if (index_up)
      begin
        index_r <= index_r + 1'b1;
      end
      if (complete_o)
      begin
        tag_sent_r  <= 1'b0;
        data_sent_r <= 1'b0;
      end
      else
      begin
        if (tag_ack)
        begin
          tag_sent_r <= 1'b1;
        end
        if (data_ack)
        begin
          data_sent_r <= 1'b1;
        end
      end
    end
  end

  // Completion only ever pops a return while a request is outstanding
  complete_in_wait_a: assert property (@(posedge clk_i) disable iff (reset_i)
    complete_o |-> (state_r inside {e_store_wait, e_uc_wait, e_fill_wait}) && ret_v_i);

endmodule

`default_nettype wire

// File: logic/pce_ret_decoder.sv
/* L1.5 return decoder */

`timescale 1ns/1ps
`default_nettype none

module pce_ret_decoder
  import pce_pkg::*;
(
  input  l15_ret_t          ret_i,
  input  logic              ret_v_i,
  input  cache_req_t        req_i,
  output logic              is_load_ret_o,
  output logic              is_st_ack_o,
  output logic              inval_v_o,
  output logic [LINE_W-1:0] fill_line_o,
  output logic [LINE_W-1:0] fill_uc_o,
  output tag_pkt_t          inval_pkt_o
);

  logic [DWORD_W-1:0] rev_0;
  logic [DWORD_W-1:0] rev_1;
  logic [DWORD_W-1:0] rev_sel;

  assign is_load_ret_o = ret_v_i & (ret_i.rtntype == e_load_ret);
  assign is_st_ack_o   = ret_v_i & (ret_i.rtntype == e_st_ack);
  assign inval_v_o     = ret_v_i & (ret_i.rtntype == e_inv_ret) & ret_i.inval;

  assign rev_0 = bswap_dword(ret_i.data_0);
  assign rev_1 = bswap_dword(ret_i.data_1);

  // Second dword lands in the upper half of the line
  assign fill_line_o = {rev_1, rev_0};

  // Uncached data comes back in the dword that holds the address
  assign rev_sel = req_i.addr[3] ? rev_1 : rev_0;

  always_comb
  begin
    unique case (req_i.size)
      e_size_1b: fill_uc_o = {(LINE_W / 8){rev_sel[7:0]}};
      e_size_2b: fill_uc_o = {(LINE_W / 16){rev_sel[15:0]}};
      e_size_4b: fill_uc_o = {(LINE_W / 32){rev_sel[31:0]}};
      default:   fill_uc_o = {(LINE_W / 64){rev_sel}};
    endcase
  end

  always_comb
  begin
    inval_pkt_o        = '0;
    inval_pkt_o.opcode = e_tag_set_state;
    inval_pkt_o.index  = ret_i.inval_index;
    inval_pkt_o.way    = ret_i.inval_way;
    inval_pkt_o.state  = e_coh_i;
  end

endmodule

`default_nettype wire

// File: logic/pce_req_encoder.sv
/* L1.5 request encoder */

`timescale 1ns/1ps
`default_nettype none

module pce_req_encoder
  import pce_pkg::*;
(
  input  cache_req_t       req_i,
  input  logic [WAY_W-1:0] way_i,
  output l15_req_t         req_o
);

  logic               is_store;
  logic               is_uc;
  logic               is_miss;
  logic [DWORD_W-1:0] rev;
  l15_size_e          size_map;
  logic [DWORD_W-1:0] data_rep;

  assign is_store = req_i.msg_type inside {e_uc_store, e_wt_store};
  assign is_uc    = req_i.msg_type inside {e_uc_store, e_uc_load};
  assign is_miss  = req_i.msg_type inside {e_miss_load, e_miss_store};

  always_comb
  begin
    unique case (req_i.size)
      e_size_1b: size_map = e_l15_size_1b;
      e_size_2b: size_map = e_l15_size_2b;
      e_size_4b: size_map = e_l15_size_4b;
      default:   size_map = e_l15_size_8b;
    endcase
  end

  // After the swap the low bytes sit at the top of the dword
  assign rev = bswap_dword(req_i.data);

  always_comb
  begin
    unique case (req_i.size)
      e_size_1b: data_rep = {8{rev[DWORD_W-1 -: 8]}};
      e_size_2b: data_rep = {4{rev[DWORD_W-1 -: 16]}};
      e_size_4b: data_rep = {2{rev[DWORD_W-1 -: 32]}};
      default:   data_rep = rev;
    endcase
  end

  always_comb
  begin
    req_o.rqtype   = is_store ? e_store_req : e_load_req;
    req_o.nc       = is_uc;
    req_o.size     = is_miss ? e_l15_size_16b : size_map;
    req_o.data     = data_rep;
    req_o.l1rplway = {req_i.addr[11], way_i};
    if (is_miss)
    begin
      // Line fill starts at the line boundary
      req_o.address = {req_i.addr[PADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    end
    else
    begin
      req_o.address = req_i.addr;
    end
  end

endmodule

`default_nettype wire

// File: logic/pce_fifo.sv
/* Small synchronous FIFO */

`timescale 1ns/1ps
`default_nettype none

module pce_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  ELS       = 8
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  payload_t data_i,
  input  logic     v_i,
  output logic     ready_o,
  output payload_t data_o,
  output logic     v_o,
  input  logic     yumi_i
);

  payload_t                 mem_r [ELS];
  logic [$clog2(ELS)-1:0]   wptr_r;
  logic [$clog2(ELS)-1:0]   rptr_r;
  logic [$clog2(ELS+1)-1:0] count_r;

  assign ready_o = (count_r != $bits(count_r)'(ELS));
  assign v_o     = (count_r != '0);
  assign data_o  = mem_r[rptr_r];

  always_ff @(posedge clk_i)
  begin
    if (v_i)
    begin
      mem_r[wptr_r] <= data_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wptr_r  <= '0;
      rptr_r  <= '0;
      count_r <= '0;
    end
    else
    begin
      if (v_i)
      begin
        wptr_r <= (wptr_r == $bits(wptr_r)'(ELS - 1)) ? '0 : wptr_r + 1'b1;
      end
      if (yumi_i)
      begin
        rptr_r <= (rptr_r == $bits(rptr_r)'(ELS - 1)) ? '0 : rptr_r + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      if (v_i && !yumi_i)
      begin
        count_r <= count_r + 1'b1;
      end
      else if (!v_i && yumi_i)
      begin
        count_r <= count_r - 1'b1;
      end
    end
  end

  no_push_full_a: assert property (@(posedge clk_i) disable iff (reset_i)
    v_i |-> ready_o);

  no_pop_empty_a: assert property (@(posedge clk_i) disable iff (reset_i)
    yumi_i |-> v_o);

endmodule

`default_nettype wire

// File: logic/pce_pkg.sv
/* PCE shared definitions */

`default_nettype none

package pce_pkg;

  localparam int PADDR_W      = 32;
  localparam int DWORD_W      = 64;
  localparam int LINE_W       = 128;
  localparam int SETS         = 64;
  localparam int ASSOC        = 2;
  localparam int INDEX_W      = $clog2(SETS);
  localparam int WAY_W        = $clog2(ASSOC);
  localparam int OFFSET_W     = $clog2(LINE_W / 8);
  localparam int TAG_W        = PADDR_W - INDEX_W - OFFSET_W;
  localparam int REQ_FIFO_ELS = 8;
  localparam int RET_FIFO_ELS = 8;

  typedef enum logic [2:0] {
    e_miss_load,
    e_miss_store,
    e_uc_load,
    e_uc_store,
    e_wt_store
  } req_msg_e;

  typedef enum logic [1:0] {
    e_size_1b,
    e_size_2b,
    e_size_4b,
    e_size_8b
  } req_size_e;

  typedef enum logic {
    e_load_req,
    e_store_req
  } l15_rqtype_e;

  // L1.5 size codes with 16B used only for line misses
  typedef enum logic [2:0] {
    e_l15_size_1b  = 3'b001,
    e_l15_size_2b  = 3'b010,
    e_l15_size_4b  = 3'b011,
    e_l15_size_8b  = 3'b100,
    e_l15_size_16b = 3'b101
  } l15_size_e;

  typedef enum logic [1:0] {
    e_load_ret,
    e_st_ack,
    e_inv_ret
  } l15_rtntype_e;

  typedef enum logic {
    e_tag_set_tag,
    e_tag_set_state
  } tag_op_e;

  typedef enum logic {
    e_data_write,
    e_data_uncached
  } data_op_e;

  typedef enum logic {
    e_coh_i,
    e_coh_m
  } coh_state_e;

  typedef struct packed {
    req_msg_e             msg_type;
    req_size_e            size;
    logic [PADDR_W-1:0]   addr;
    logic [DWORD_W-1:0]   data;
  } cache_req_t;

  typedef struct packed {
    l15_rqtype_e          rqtype;
    logic                 nc;
    l15_size_e            size;
    logic [PADDR_W-1:0]   address;
    logic [DWORD_W-1:0]   data;
    logic [1:0]           l1rplway;
  } l15_req_t;

  typedef struct packed {
    l15_rtntype_e         rtntype;
    logic                 noncacheable;
    logic [DWORD_W-1:0]   data_0;
    logic [DWORD_W-1:0]   data_1;
    logic                 inval;
    logic [WAY_W-1:0]     inval_way;
    logic [INDEX_W-1:0]   inval_index;
  } l15_ret_t;

  typedef struct packed {
    tag_op_e              opcode;
    logic [INDEX_W-1:0]   index;
    logic [WAY_W-1:0]     way;
    logic [TAG_W-1:0]     tag;
    coh_state_e           state;
  } tag_pkt_t;

  typedef struct packed {
    data_op_e             opcode;
    logic [INDEX_W-1:0]   index;
    logic [WAY_W-1:0]     way;
    logic [LINE_W-1:0]    data;
  } data_pkt_t;

  // L1.5 side is big endian
  function automatic logic [DWORD_W-1:0] bswap_dword(input logic [DWORD_W-1:0] d);
    logic [DWORD_W-1:0] r;
    for (int i = 0; i < DWORD_W / 8; i++)
    begin
      r[8*i +: 8] = d[DWORD_W-8-8*i +: 8];
    end
    return r;
  endfunction

endpackage

`default_nettype wire
